/* hdl/hsid_pkg.sv */
package hsid_pkg;

  localparam int WORD_W   = 32;  // Bus and memory word
  localparam int SAMPLE_W = 16;  // One band sample
  localparam int MUL_W    = 32;  // Square of a sample difference
  localparam int ACC_W    = 48;  // Per-channel running sum
  localparam int REF_W    = 12;  // Library index, up to 4096 entries
  localparam int BANDS_W  = 9;   // Band count, up to 256
  localparam int ADR_W    = 12;  // Wishbone word address

  typedef logic [WORD_W-1:0]   word_t;
  typedef logic [SAMPLE_W-1:0] sample_t;
  typedef logic [MUL_W-1:0]    sq_t;
  typedef logic [ACC_W-1:0]    acc_t;
  typedef logic [REF_W-1:0]    ref_t;
  typedef logic [BANDS_W-1:0]  bands_t;

  typedef struct packed {
    logic  valid;   // Element present this cycle
    logic  start;   // First word of a library entry
    logic  last;    // Final word of a library entry
    ref_t  ref_id;  // Library entry index
    word_t a;       // Pixel word, two samples
    word_t b;       // Library word, two samples
  } element_t;

  typedef struct packed {
    logic  valid;
    ref_t  ref_id;
    word_t value;   // MSE of this entry
  } mse_result_t;

  typedef enum logic [1:0] {S_IDLE, S_RUN, S_DRAIN} stream_state_e;

  localparam logic [ADR_W-1:0] REG_CTRL      = 12'd0;  // Bit 0 starts a run
  localparam logic [ADR_W-1:0] REG_BANDS     = 12'd1;
  localparam logic [ADR_W-1:0] REG_LIB_COUNT = 12'd2;
  localparam logic [ADR_W-1:0] REG_STATUS    = 12'd3;  // Bit 0 busy, bit 1 done
  localparam logic [ADR_W-1:0] REG_BEST_REF  = 12'd4;
  localparam logic [ADR_W-1:0] REG_BEST_MSE  = 12'd5;
  localparam logic [ADR_W-1:0] PIX_BASE      = 12'd256;   // Pixel memory window
  localparam logic [ADR_W-1:0] LIB_BASE      = 12'd1024;  // Library memory window

endpackage

/* hdl/hsid_sq_df_acc.sv */
`timescale 1ns/1ps

module hsid_sq_df_acc import hsid_pkg::*; #(
  parameter int HSI_LIBRARY_SIZE = 8
) (
  input  logic    clk,
  input  logic    rst_n,
  input  logic    data_in_valid,
  input  logic    initial_acc_en,  // Restart the sum on this element
  input  acc_t    initial_acc,
  input  sample_t data_in_a,
  input  sample_t data_in_b,
  input  ref_t    data_in_ref,
  input  logic    data_in_last,
  output logic    acc_valid,
  output logic    acc_last,
  output acc_t    acc_value,
  output ref_t    acc_ref
);

  logic    s1_valid, s1_start, s1_last;  // Stage 1 flags
  logic    s2_valid, s2_start, s2_last;  // Stage 2 flags
  ref_t    s1_ref, s2_ref;
  acc_t    s1_init, s2_init;             // Start value follows its element
  sample_t s1_diff;                      // |a - b|
  sq_t     s2_sq;                        // Squared difference

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid  <= 1'b0;
      s1_start  <= 1'b0;
      s1_last   <= 1'b0;
      s2_valid  <= 1'b0;
      s2_start  <= 1'b0;
      s2_last   <= 1'b0;
      acc_valid <= 1'b0;
      acc_last  <= 1'b0;
      acc_value <= '0;
    end else begin
      s1_valid  <= data_in_valid;
      s1_start  <= data_in_valid && initial_acc_en;
      s1_last   <= data_in_valid && data_in_last;
      s2_valid  <= s1_valid;              // Square stage
      s2_start  <= s1_start;
      s2_last   <= s1_last;
      acc_valid <= s2_valid;              // One pulse per element
      acc_last  <= s2_last;
      if (s2_valid) begin
        acc_value <= (s2_start ? s2_init : acc_value) + acc_t'(s2_sq);  // Load or accumulate
      end
    end
  end

  // Datapath registers carry no reset
  always_ff @(posedge clk) begin
    s1_diff <= (data_in_a > data_in_b) ? data_in_a - data_in_b : data_in_b - data_in_a;
    s1_ref  <= data_in_ref;
    s1_init <= initial_acc;
    s2_sq   <= sq_t'(s1_diff) * sq_t'(s1_diff);  // Full 32-bit product
    s2_ref  <= s1_ref;
    s2_init <= s1_init;
    acc_ref <= s2_ref;
  end

  // Framing from the streamer: last only on a real element of a known entry
  assert property (@(posedge clk) disable iff (!rst_n)
    data_in_last |-> data_in_valid && (int'(data_in_ref) < HSI_LIBRARY_SIZE));

endmodule

/* hdl/hsid_mse.sv */
`timescale 1ns/1ps

module hsid_mse import hsid_pkg::*; #(
  parameter int HSI_BANDS        = 16,
  parameter int HSI_LIBRARY_SIZE = 8
) (
  input  logic        clk,
  input  logic        rst_n,
  input  element_t    element,
  input  bands_t      hsi_bands,  // Active band count, divisor
  output mse_result_t result
);

  logic         ch1_valid, ch2_valid;
  logic         ch1_last, ch2_last;
  acc_t         ch1_value, ch2_value;
  ref_t         ch1_ref, ch2_ref;
  logic         sum_en;              // Both channels closed the same entry
  logic         sum_valid;
  logic [ACC_W:0] sum_value;         // One extra bit for the channel sum
  ref_t         sum_ref;
  logic [ACC_W:0] quot;
  logic         mse_valid;
  ref_t         mse_ref;
  word_t        mse_value;

  assign sum_en = ch1_valid && ch2_valid && ch1_last && ch2_last && (ch1_ref == ch2_ref);
  assign quot   = sum_value / hsi_bands;  // Floor division

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sum_valid <= 1'b0;
      mse_valid <= 1'b0;
    end else begin
      sum_valid <= sum_en;
      mse_valid <= sum_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (sum_en) begin
      sum_value <= {1'b0, ch1_value} + {1'b0, ch2_value};  // Both halves of the word
      sum_ref   <= ch1_ref;
    end
    if (sum_valid) begin
      mse_value <= quot[WORD_W-1:0];
      mse_ref   <= sum_ref;
    end
  end

  assign result = '{valid: mse_valid, ref_id: mse_ref, value: mse_value};

  hsid_sq_df_acc #(.HSI_LIBRARY_SIZE(HSI_LIBRARY_SIZE)) channel_1 (
    .clk            (clk),
    .rst_n          (rst_n),
    .data_in_valid  (element.valid),
    .initial_acc_en (element.valid && element.start),  // Fresh sum per entry
    .initial_acc    ('0),
    .data_in_a      (element.a[SAMPLE_W-1:0]),          // Low halves
    .data_in_b      (element.b[SAMPLE_W-1:0]),
    .data_in_ref    (element.ref_id),
    .data_in_last   (element.last),
    .acc_valid      (ch1_valid),
    .acc_last       (ch1_last),
    .acc_value      (ch1_value),
    .acc_ref        (ch1_ref)
  );

  hsid_sq_df_acc #(.HSI_LIBRARY_SIZE(HSI_LIBRARY_SIZE)) channel_2 (
    .clk            (clk),
    .rst_n          (rst_n),
    .data_in_valid  (element.valid),
    .initial_acc_en (element.valid && element.start),
    .initial_acc    ('0),
    .data_in_a      (element.a[WORD_W-1:SAMPLE_W]),     // High halves
    .data_in_b      (element.b[WORD_W-1:SAMPLE_W]),
    .data_in_ref    (element.ref_id),
    .data_in_last   (element.last),
    .acc_valid      (ch2_valid),
    .acc_last       (ch2_last),
    .acc_value      (ch2_value),
    .acc_ref        (ch2_ref)
  );

  // The two channels must run in lockstep
  assert property (@(posedge clk) disable iff (!rst_n)
    (ch1_valid || ch2_valid) |-> ch1_valid && ch2_valid
      && (ch1_ref == ch2_ref) && (ch1_last == ch2_last));

  // Divisor stays within the configured band range
  assert property (@(posedge clk) disable iff (!rst_n)
    sum_valid |-> (hsi_bands != '0) && (int'(hsi_bands) <= HSI_BANDS));

endmodule

/* hdl/hsid_wb_regs.sv */
`timescale 1ns/1ps

module hsid_wb_regs import hsid_pkg::*; #(
  parameter int HSI_LIBRARY_SIZE = 8
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             wb_cyc,
  input  logic             wb_stb,
  input  logic             wb_we,
  input  logic [ADR_W-1:0] wb_adr,
  input  word_t            wb_dat_w,
  input  logic [3:0]       wb_sel,    // Whole words only
  output word_t            wb_dat_r,
  output logic             wb_ack,
  output logic             start,     // One-cycle run start
  output bands_t           bands,
  output ref_t             lib_count,
  output logic             mem_we,
  output logic [ADR_W-1:0] mem_addr,
  output word_t            mem_data,
  input  logic             done,
  input  ref_t             best_ref,
  input  word_t            best_mse
);

  logic  req, req_q, hit;
  logic  busy, done_flag;
  logic  cfg_ok;                       // Run may start with this setup
  ref_t  best_ref_q;
  word_t best_mse_q;
  word_t rd_data;

  assign req    = wb_cyc && wb_stb;
  assign hit    = req && !req_q;       // One transfer per request
  assign cfg_ok = (bands != '0) && !bands[0] && (lib_count != '0)
                  && (int'(lib_count) <= HSI_LIBRARY_SIZE);

  always_comb begin
    case (wb_adr)
      REG_BANDS:     rd_data = word_t'(bands);
      REG_LIB_COUNT: rd_data = word_t'(lib_count);
      REG_STATUS:    rd_data = word_t'({done_flag, busy});
      REG_BEST_REF:  rd_data = word_t'(best_ref_q);
      REG_BEST_MSE:  rd_data = best_mse_q;
      default:       rd_data = '0;     // CTRL and memory windows
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      req_q <= 1'b0;
      wb_ack <= 1'b0;
      wb_dat_r <= '0;
      start <= 1'b0;
      mem_we <= 1'b0;
      busy <= 1'b0;
      done_flag <= 1'b0;
      bands <= '0;
      lib_count <= '0;
      best_ref_q <= '0;
      best_mse_q <= '0;
    end else begin
      req_q  <= req;
      wb_ack <= hit;
      start  <= 1'b0;
      mem_we <= 1'b0;
      if (hit) wb_dat_r <= rd_data;
      if (hit && wb_we && !busy) begin  // Setup is frozen during a run
        case (wb_adr)
          REG_CTRL: begin
            if (wb_dat_w[0] && cfg_ok) begin
              start     <= 1'b1;
              busy      <= 1'b1;
              done_flag <= 1'b0;       // Sticky done clears here
            end
          end
          REG_BANDS:     bands <= wb_dat_w[BANDS_W-1:0];
          REG_LIB_COUNT: lib_count <= wb_dat_w[REF_W-1:0];
          default:       mem_we <= (wb_adr >= PIX_BASE);  // Memory windows
        endcase
      end
      if (done) begin
        busy       <= 1'b0;
        done_flag  <= 1'b1;
        best_ref_q <= best_ref;        // Hold results for the host
        best_mse_q <= best_mse;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (hit) begin
      mem_addr <= wb_adr;
      mem_data <= wb_dat_w;
    end
  end

  // Master keeps the request up while ack is high
  assert property (@(posedge clk) disable iff (!rst_n)
    wb_ack |-> wb_cyc && wb_stb);

endmodule

/* hdl/hsid_streamer.sv */
`timescale 1ns/1ps

module hsid_streamer import hsid_pkg::*; #(
  parameter int HSI_BANDS        = 16,
  parameter int HSI_LIBRARY_SIZE = 8
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             start,
  input  bands_t           bands,
  input  ref_t             lib_count,
  input  logic             mem_we,
  input  logic [ADR_W-1:0] mem_addr,
  input  word_t            mem_data,
  output element_t         element
);

  localparam int WORDS     = HSI_BANDS / 2;            // Words per spectrum
  localparam int LIB_WORDS = HSI_LIBRARY_SIZE * WORDS;
  localparam int PIX_AW    = $clog2(WORDS);
  localparam int LIB_AW    = $clog2(LIB_WORDS);

  word_t pix_mem [WORDS];
  word_t lib_mem [LIB_WORDS];

  stream_state_e            state;
  logic [BANDS_W-2:0]       word_idx;     // Word within an entry
  logic [BANDS_W-2:0]       last_word;
  ref_t                     entry_idx;
  logic                     rd_valid, rd_last;
  logic [PIX_AW-1:0]        pix_rd_addr;
  logic [LIB_AW-1:0]        lib_rd_addr;
  logic [ADR_W-1:0]         pix_off, lib_off;
  logic                     elem_valid, elem_start, elem_last;
  ref_t                     elem_ref;
  word_t                    elem_a, elem_b;

  assign last_word   = bands[BANDS_W-1:1] - 1'b1;  // bands/2 - 1
  assign rd_valid    = (state == S_RUN);
  assign rd_last     = (word_idx == last_word);
  assign pix_rd_addr = word_idx[PIX_AW-1:0];
  assign lib_rd_addr = LIB_AW'(int'(entry_idx) * WORDS + int'(word_idx));
  assign pix_off     = mem_addr - PIX_BASE;
  assign lib_off     = mem_addr - LIB_BASE;

  // Host write port and synchronous reads
  always_ff @(posedge clk) begin
    if (mem_we) begin
      if (mem_addr >= LIB_BASE) begin
        if (int'(lib_off) < LIB_WORDS) lib_mem[lib_off[LIB_AW-1:0]] <= mem_data;
      end else if (mem_addr >= PIX_BASE && int'(pix_off) < WORDS) begin
        pix_mem[pix_off[PIX_AW-1:0]] <= mem_data;
      end
    end
    elem_a <= pix_mem[pix_rd_addr];
    elem_b <= lib_mem[lib_rd_addr];
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= S_IDLE;
      word_idx <= '0;
      entry_idx <= '0;
      elem_valid <= 1'b0;
      elem_start <= 1'b0;
      elem_last <= 1'b0;
      elem_ref <= '0;
    end else begin
      elem_valid <= rd_valid;                          // Aligned with read data
      elem_start <= rd_valid && (word_idx == '0);
      elem_last  <= rd_valid && rd_last;
      elem_ref   <= entry_idx;
      case (state)
        S_IDLE: begin
          if (start) begin
            state     <= S_RUN;
            word_idx  <= '0;
            entry_idx <= '0;
          end
        end
        S_RUN: begin
          if (rd_last) begin
            word_idx <= '0;
            if (entry_idx == lib_count - 1'b1) state <= S_DRAIN;  // Final entry issued
            else entry_idx <= entry_idx + 1'b1;
          end else begin
            word_idx <= word_idx + 1'b1;
          end
        end
        default: state <= S_IDLE;                      // Last read lands
      endcase
    end
  end

  assign element = '{valid: elem_valid, start: elem_start, last: elem_last,
                     ref_id: elem_ref, a: elem_a, b: elem_b};

  assert property (@(posedge clk) disable iff (!rst_n)
    start |-> (bands != '0) && !bands[0] && (int'(bands) <= HSI_BANDS));

endmodule

/* hdl/hsid_min_search.sv */
`timescale 1ns/1ps

module hsid_min_search import hsid_pkg::*; #(
  parameter int HSI_LIBRARY_SIZE = 8
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        start,
  input  ref_t        lib_count,
  input  mse_result_t result,
  output ref_t        best_ref,
  output word_t       best_mse,
  output logic        done      // Pulse when all entries are in
);

  ref_t count;                  // Results seen this run
  logic final_res;

  assign final_res = result.valid && (count == lib_count - 1'b1);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count    <= '0;
      best_ref <= '0;
      best_mse <= '1;
      done     <= 1'b0;
    end else begin
      done <= final_res;
      if (start) begin
        count    <= '0;
        best_ref <= '0;
        best_mse <= '1;         // Any result beats this
      end else if (result.valid) begin
        count <= count + 1'b1;
        if (result.value < best_mse) begin  // Strict, ties keep lower index
          best_mse <= result.value;
          best_ref <= result.ref_id;
        end
      end
    end
  end

  // No more results than entries requested
  assert property (@(posedge clk) disable iff (!rst_n)
    result.valid |-> (count < lib_count) && (int'(result.ref_id) < HSI_LIBRARY_SIZE));

endmodule

/* hdl/hsid_top.sv */
`timescale 1ns/1ps

module hsid_top import hsid_pkg::*; #(
  parameter int HSI_BANDS        = 16,
  parameter int HSI_LIBRARY_SIZE = 8
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             wb_cyc,
  input  logic             wb_stb,
  input  logic             wb_we,
  input  logic [ADR_W-1:0] wb_adr,
  input  word_t            wb_dat_w,
  input  logic [3:0]       wb_sel,
  output word_t            wb_dat_r,
  output logic             wb_ack
);

  logic             start, done, mem_we;
  bands_t           bands;
  ref_t             lib_count, best_ref;
  word_t            best_mse, mem_data;
  logic [ADR_W-1:0] mem_addr;
  element_t         element;   // Streamer to MSE
  mse_result_t      result;    // MSE to min search

  hsid_wb_regs #(.HSI_LIBRARY_SIZE(HSI_LIBRARY_SIZE)) u_regs (
    .clk(clk), .rst_n(rst_n),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
    .wb_dat_w(wb_dat_w), .wb_sel(wb_sel), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
    .start(start), .bands(bands), .lib_count(lib_count),
    .mem_we(mem_we), .mem_addr(mem_addr), .mem_data(mem_data),
    .done(done), .best_ref(best_ref), .best_mse(best_mse)
  );

  hsid_streamer #(.HSI_BANDS(HSI_BANDS), .HSI_LIBRARY_SIZE(HSI_LIBRARY_SIZE)) u_streamer (
    .clk(clk), .rst_n(rst_n), .start(start), .bands(bands), .lib_count(lib_count),
    .mem_we(mem_we), .mem_addr(mem_addr), .mem_data(mem_data), .element(element)
  );

  hsid_mse #(.HSI_BANDS(HSI_BANDS), .HSI_LIBRARY_SIZE(HSI_LIBRARY_SIZE)) u_mse (
    .clk(clk), .rst_n(rst_n), .element(element), .hsi_bands(bands), .result(result)
  );

  hsid_min_search #(.HSI_LIBRARY_SIZE(HSI_LIBRARY_SIZE)) u_min (
    .clk(clk), .rst_n(rst_n), .start(start), .lib_count(lib_count), .result(result),
    .best_ref(best_ref), .best_mse(best_mse), .done(done)
  );

endmodule

/* bench/hsid_tb.sv */
`timescale 1ns/1ps

module hsid_tb import hsid_pkg::*; ();

  localparam int TB_BANDS   = 16;            // DUT default parameters
  localparam int TB_LIB     = 8;
  localparam int WORDS      = TB_BANDS / 2;  // Memory words per spectrum
  localparam int N_TESTS    = 5;
  localparam int ACK_LIMIT  = 8;             // Cycles to wait for ack
  localparam int POLL_LIMIT = 100;           // Status reads before giving up

  typedef enum logic [1:0] {FILL_RANDOM, FILL_MATCH, FILL_DUP} fill_e;

  typedef struct packed {
    bands_t bands;
    ref_t   lib_count;
    fill_e  mode;
    ref_t   exp_ref;   // Fixed winner for match and duplicate fills
  } test_t;

  logic             clk, rst_n;
  logic             wb_cyc, wb_stb, wb_we, wb_ack;
  logic [ADR_W-1:0] wb_adr;
  logic [3:0]       wb_sel;
  word_t            wb_dat_w, wb_dat_r;

  test_t tests [N_TESTS];
  word_t pix [WORDS];               // Host copy of the pixel
  word_t lib [TB_LIB*WORDS];        // Host copy of the library
  int    errors, checks, fails, runs, seed_val;
  logic  timed_out;

  hsid_top DUT (
    .clk(clk), .rst_n(rst_n), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
    .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_sel(wb_sel), .wb_dat_r(wb_dat_r),
    .wb_ack(wb_ack)
  );

  always #2 clk = ~clk;             // 4 ns period

  task automatic check_value(input string name, input word_t got, input word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error: %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  // One Wishbone classic transfer with the request held through ack
  task automatic wb_access(input logic we, input logic [ADR_W-1:0] adr,
                           input word_t wdata, output word_t rdata);
    int n;
    rdata = '0;
    if (!timed_out) begin
      @(posedge clk);
      #0.5;                         // Idle cycle before keeps each request new
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = we;
      wb_adr   = adr;
      wb_dat_w = wdata;
      n = 0;
      while (!wb_ack && n < ACK_LIMIT) begin
        @(posedge clk);
        #0.5;                       // Ack and read data settled here
        n++;
      end
      rdata = wb_dat_r;
      if (wb_ack) begin
        @(posedge clk);             // Transfer ends on the edge that sees ack
        #0.5;
      end else begin
        $display("timeout: no ack for bus access at address 0x%h", adr);
        errors++;
        timed_out = 1'b1;
      end
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
    end
  endtask

  task automatic wb_write(input logic [ADR_W-1:0] adr, input word_t data);
    word_t unused;
    wb_access(1'b1, adr, data, unused);
  endtask

  task automatic wait_done();
    word_t st;
    int    n;
    st = '0;
    n  = 0;
    while (!timed_out && !st[1] && n < POLL_LIMIT) begin
      wb_access(1'b0, REG_STATUS, '0, st);
      n++;
    end
    if (!timed_out && !st[1]) begin
      $display("timeout: run did not report done after %0d status reads", n);
      errors++;
      timed_out = 1'b1;
    end
  endtask

  function automatic test_t make_test(input int bands, input int count, input fill_e mode,
                                      input int exp_ref);
    test_t t;
    t.bands     = bands_t'(bands);
    t.lib_count = ref_t'(count);
    t.mode      = mode;
    t.exp_ref   = ref_t'(exp_ref);
    return t;
  endfunction

  // Floor-divided sum of squares per entry and the lowest index on ties
  task automatic model_best(input int bands, input int count, output ref_t best_ref,
                            output word_t best_mse);
    longint sum, d_lo, d_hi, mse, best;
    best     = 64'h0000_0000_FFFF_FFFF;  // Only a strictly smaller MSE wins
    best_ref = '0;
    for (int r = 0; r < count; r++) begin
      sum = 0;
      for (int w = 0; w < bands / 2; w++) begin
        d_lo = longint'(pix[w][SAMPLE_W-1:0]) - longint'(lib[r*WORDS+w][SAMPLE_W-1:0]);
        d_hi = longint'(pix[w][WORD_W-1:SAMPLE_W]) - longint'(lib[r*WORDS+w][WORD_W-1:SAMPLE_W]);
        sum += d_lo * d_lo + d_hi * d_hi;
      end
      mse = sum / bands;
      if (mse < best) begin
        best     = mse;
        best_ref = ref_t'(r);
      end
    end
    best_mse = word_t'(best);
  endtask

  task automatic fill_memories(input test_t t);
    int k, last;
    k    = int'(t.exp_ref);
    last = int'(t.lib_count) - 1;
    for (int w = 0; w < WORDS; w++) pix[w] = $urandom;
    for (int i = 0; i < TB_LIB * WORDS; i++) lib[i] = $urandom;  // Unused words too
    for (int w = 0; w < WORDS; w++) begin
      if (t.mode == FILL_MATCH) lib[k*WORDS+w] = pix[w];
      if (t.mode == FILL_DUP) begin
        lib[k*WORDS+w]    = pix[w] ^ 32'h0001_0001;  // Off by one in every band
        lib[last*WORDS+w] = lib[k*WORDS+w];           // Same MSE at a higher index
      end
    end
  endtask

  task automatic reg_test();
    word_t rd;
    int    errs_before;
    errs_before = errors;
    wb_access(1'b0, REG_STATUS, '0, rd);
    if (!timed_out) check_value("status", rd, 32'h0);      // Idle after reset
    wb_write(REG_BANDS, 32'd16);
    wb_access(1'b0, REG_BANDS, '0, rd);
    if (!timed_out) check_value("bands", rd, 32'd16);
    wb_write(REG_LIB_COUNT, 32'd5);
    wb_access(1'b0, REG_LIB_COUNT, '0, rd);
    if (!timed_out) check_value("lib_count", rd, 32'd5);
    wb_access(1'b0, PIX_BASE, '0, rd);
    if (!timed_out) check_value("pixel window read", rd, 32'h0);
    runs++;
    if (errors != errs_before) fails++;
    $display("registers: %s", (errors == errs_before) ? "ok" : "failed");
  endtask

  task automatic run_test(input int idx);
    test_t t;
    ref_t  exp_ref;
    word_t exp_mse, rd;
    int    errs_before;
    t = tests[idx];
    errs_before = errors;
    fill_memories(t);
    for (int w = 0; w < WORDS; w++) wb_write(PIX_BASE + ADR_W'(w), pix[w]);
    for (int i = 0; i < TB_LIB * WORDS; i++) wb_write(LIB_BASE + ADR_W'(i), lib[i]);
    wb_write(REG_BANDS, word_t'(t.bands));
    wb_write(REG_LIB_COUNT, word_t'(t.lib_count));
    wb_write(REG_CTRL, 32'd1);
    wb_access(1'b0, REG_STATUS, '0, rd);
    if (!timed_out) check_value("status after start", rd, 32'h1);  // Busy with done cleared
    wait_done();
    model_best(int'(t.bands), int'(t.lib_count), exp_ref, exp_mse);
    if (t.mode != FILL_RANDOM) exp_ref = t.exp_ref;  // Winner fixed by the fill
    wb_access(1'b0, REG_BEST_REF, '0, rd);
    if (!timed_out) check_value("best_ref", rd, word_t'(exp_ref));
    wb_access(1'b0, REG_BEST_MSE, '0, rd);
    if (!timed_out) check_value("best_mse", rd, exp_mse);
    runs++;
    if (errors != errs_before) fails++;
    $display("test %0d: bands %0d entries %0d best %0d mse 0x%h %s", idx, t.bands,
             t.lib_count, exp_ref, exp_mse, (errors == errs_before) ? "ok" : "failed");
  endtask

  initial begin
    clk       = 1'b0;
    rst_n     = 1'b0;
    wb_cyc    = 1'b0;
    wb_stb    = 1'b0;
    wb_we     = 1'b0;
    wb_adr    = '0;
    wb_dat_w  = '0;
    wb_sel    = 4'hF;               // Whole words
    errors    = 0;
    checks    = 0;
    fails     = 0;
    runs      = 0;
    timed_out = 1'b0;
    seed_val  = $urandom(65);
    tests[0]  = make_test(16, 8, FILL_MATCH, 3);   // Exact match among random entries
    tests[1]  = make_test(16, 8, FILL_RANDOM, 0);
    tests[2]  = make_test(8, 5, FILL_RANDOM, 0);   // Upper words must not count
    tests[3]  = make_test(8, 5, FILL_MATCH, 4);
    tests[4]  = make_test(16, 8, FILL_DUP, 2);     // Tie with entry 7
    repeat (5) @(posedge clk);
    #0.5;
    rst_n = 1'b1;
    reg_test();
    for (int i = 0; i < N_TESTS && !timed_out; i++) run_test(i);
    $display("%0d tests run, %0d failed, %0d checks, %0d errors", runs, fails, checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

/* files.f */
hdl/hsid_pkg.sv
hdl/hsid_sq_df_acc.sv
hdl/hsid_mse.sv
hdl/hsid_wb_regs.sv
hdl/hsid_streamer.sv
hdl/hsid_min_search.sv
hdl/hsid_top.sv
bench/hsid_tb.sv

/* Bender.yml */
package:
  name: hsid

sources:
  - hdl/hsid_pkg.sv
  - hdl/hsid_sq_df_acc.sv
  - hdl/hsid_mse.sv
  - hdl/hsid_wb_regs.sv
  - hdl/hsid_streamer.sv
  - hdl/hsid_min_search.sv
  - hdl/hsid_top.sv
  - target: test
    files:
      - bench/hsid_tb.sv
